//--- verilog/wb_master_defines.svh
/*
 * bus geometry for the wishbone master
 *  - address and data widths
 *  - number of byte lanes
 *  - beats in one cache line fill
 */
`ifndef WB_MASTER_DEFINES_SVH
`define WB_MASTER_DEFINES_SVH

// ====================
// bus widths
// ====================

// byte address width on the wishbone side
`define WB_ADDR_W 32

// data word width, both read and write paths
`define WB_DATA_W 32

// one select bit for each byte of the data word
`define WB_SEL_W 4

// ====================
// line fills
// ====================

// a 16 byte cache line is moved as four wrapping word beats
`define WB_BURST_BEATS 4

`endif

//--- verilog/wb_master_pkg.sv
/*
 * shared types of the wishbone master
 *  - requester source enum
 *  - address word union with line, word and lane fields
 *  - cache request, granted bus request and wishbone output structs
 */
`include "wb_master_defines.svh"

package wb_master_pkg;

    // which cache port the current bus cycle belongs to
    typedef enum logic {
        SRC_ICACHE = 1'b0,
        SRC_DCACHE = 1'b1
    } req_src_e;

    // one address word, seen either whole or split at the line boundary
    // word selects the 32 bit word inside a 16 byte line, lane the byte
    typedef union packed {
        logic [`WB_ADDR_W-1:0] raw;
        struct packed {
            logic [`WB_ADDR_W-5:0] line;
            logic [1:0]            word;
            logic [1:0]            lane;
        } f;
    } wb_addr_u;

    // instruction cache port, reads only
    typedef struct packed {
        logic                  valid;
        logic                  qword;
        logic [`WB_ADDR_W-1:0] address;
    } icache_req_t;

    // data cache port, byte enables only matter for writes
    typedef struct packed {
        logic                  valid;
        logic                  qword;
        logic                  write;
        logic [`WB_SEL_W-1:0]  byte_enable;
        logic [`WB_DATA_W-1:0] write_data;
        logic [`WB_ADDR_W-1:0] address;
    } dcache_req_t;

    // request that won arbitration, already in bus form
    typedef struct packed {
        req_src_e              src;
        logic                  we;
        logic                  burst;
        logic [`WB_SEL_W-1:0]  sel;
        wb_addr_u              addr;
        logic [`WB_DATA_W-1:0] wdata;
    } bus_req_t;

    // master side of the wishbone bus
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`WB_SEL_W-1:0]  sel;
        logic [`WB_ADDR_W-1:0] adr;
        logic [`WB_DATA_W-1:0] dat;
    } wb_master_t;

endpackage

//--- verilog/wb_request_arbiter.sv
/*
 * request arbiter of the wishbone master
 *  - data port has fixed priority over the instruction port
 *  - builds the bus request with byte lane selects
 *  - derives the two low address bits from the byte enables
 *  - masks the finished requester for one cycle
 */
`include "wb_master_defines.svh"

module wb_request_arbiter
    import wb_master_pkg::*;
(
    input  logic        i_clk,
    input  logic        quick_n_reset,
    input  icache_req_t i_icache,
    input  dcache_req_t i_dcache,
    input  logic        i_idle,
    output logic        o_grant,
    output bus_req_t    o_bus_req
);

    logic                 idle_q;
    req_src_e             last_src_q;
    logic                 just_done;
    logic                 pick_dcache;
    logic                 icache_pend;
    logic [`WB_SEL_W-1:0] sel;
    wb_addr_u             addr;

    // idle rising means the last ready went out in the previous cycle
    assign just_done = i_idle && !idle_q;

    // the served requester still shows its old valid in this one cycle
    assign pick_dcache = i_dcache.valid && !(just_done && last_src_q == SRC_DCACHE);
    assign icache_pend = i_icache.valid && !(just_done && last_src_q == SRC_ICACHE);

    assign o_grant = i_idle && (pick_dcache || icache_pend);

    always_comb
    begin
        // instruction reads and data reads take the whole word
        if (pick_dcache && i_dcache.write)
            sel = i_dcache.byte_enable;
        else
            sel = {`WB_SEL_W{1'b1}};

        addr.raw = pick_dcache ? i_dcache.address : i_icache.address;

        // low bits follow the enables, so a full word ends up aligned
        case (sel)
            4'b0001: addr.f.lane = 2'd0;
            4'b0010: addr.f.lane = 2'd1;
            4'b0100: addr.f.lane = 2'd2;
            4'b1000: addr.f.lane = 2'd3;
            4'b1100: addr.f.lane = 2'd2;
            default: addr.f.lane = 2'd0;
        endcase

        o_bus_req.src   = pick_dcache ? SRC_DCACHE : SRC_ICACHE;
        o_bus_req.we    = pick_dcache && i_dcache.write;
        // writes are always single beats
        o_bus_req.burst = pick_dcache ? (i_dcache.qword && !i_dcache.write) : i_icache.qword;
        o_bus_req.sel   = sel;
        o_bus_req.addr  = addr;
        o_bus_req.wdata = i_dcache.write_data;
    end

    // ====================
    // re-grant mask state
    // ====================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            // start as idle so nothing is masked right after reset
            idle_q     <= 1'b1;
            last_src_q <= SRC_ICACHE;
        end
        else
        begin
            idle_q <= i_idle;
            if (o_grant)
                last_src_q <= o_bus_req.src;
        end
    end

endmodule

//--- verilog/wb_burst_sequencer.sv
/*
 * bus cycle sequencer of the wishbone master
 *  - FSM with idle, burst and wait for last ack states
 *  - registers the granted request onto the bus
 *  - wrapping four beat line fills
 *  - beat and last beat strobes for the response side
 */
`include "wb_master_defines.svh"

module wb_burst_sequencer
    import wb_master_pkg::*;
(
    input  logic       i_clk,
    input  logic       quick_n_reset,
    input  logic       i_grant,
    input  bus_req_t   i_bus_req,
    input  logic       i_wb_ack,
    output wb_master_t o_wb,
    output logic       o_idle,
    output logic       o_beat_ack,
    output logic       o_last_beat
);

    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_BURST     = 2'd1;
    localparam logic [1:0] ST_WAIT_LAST = 2'd2;
    localparam int         BEAT_W       = $clog2(`WB_BURST_BEATS);

    logic [1:0]            state_q;
    logic [BEAT_W-1:0]     beat_q;
    logic                  active_q;
    logic                  we_q;
    logic [`WB_SEL_W-1:0]  sel_q;
    wb_addr_u              addr_q;
    logic [`WB_DATA_W-1:0] dat_q;

    assign o_idle      = (state_q == ST_IDLE);
    // a beat completes whenever strobe and ack meet
    assign o_beat_ack  = active_q && i_wb_ack;
    assign o_last_beat = (state_q == ST_WAIT_LAST);

    // ====================
    // control FSM
    // ====================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_q  <= ST_IDLE;
            active_q <= 1'b0;
            we_q     <= 1'b0;
            beat_q   <= '0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (i_grant)
                    begin
                        active_q <= 1'b1;
                        we_q     <= i_bus_req.we;
                        beat_q   <= '0;
                        state_q  <= i_bus_req.burst ? ST_BURST : ST_WAIT_LAST;
                    end
                end
                ST_BURST:
                begin
                    // all beats but the last one are counted here
                    if (i_wb_ack)
                    begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == BEAT_W'(`WB_BURST_BEATS - 2))
                            state_q <= ST_WAIT_LAST;
                    end
                end
                ST_WAIT_LAST:
                begin
                    // drop the cycle right after the final ack
                    if (i_wb_ack)
                    begin
                        active_q <= 1'b0;
                        we_q     <= 1'b0;
                        state_q  <= ST_IDLE;
                    end
                end
                default:
                    state_q <= ST_IDLE;
            endcase
        end
    end

    // ====================
    // bus payload
    // ====================

    always_ff @(posedge i_clk)
    begin
        if (state_q == ST_IDLE && i_grant)
        begin
            sel_q  <= i_bus_req.sel;
            addr_q <= i_bus_req.addr;
            dat_q  <= i_bus_req.wdata;
        end
        else if (state_q == ST_BURST && i_wb_ack)
            // only the word field moves, so the fill wraps inside its line
            addr_q.f.word <= addr_q.f.word + 2'd1;
    end

    always_comb
    begin
        o_wb.cyc = active_q;
        o_wb.stb = active_q;
        o_wb.we  = we_q;
        o_wb.sel = sel_q;
        o_wb.adr = addr_q.raw;
        o_wb.dat = dat_q;
    end

endmodule

//--- verilog/wb_response_router.sv
/*
 * response router of the wishbone master
 *  - remembers which cache port owns the bus cycle
 *  - steers each ack to that port's ready
 *  - passes read data to both ports
 */
`include "wb_master_defines.svh"

module wb_response_router
    import wb_master_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  quick_n_reset,
    input  logic                  i_grant,
    input  req_src_e              i_src,
    input  logic                  i_beat_ack,
    input  logic                  i_last_beat,
    input  logic [`WB_DATA_W-1:0] i_wb_dat,
    output logic                  o_icache_ready,
    output logic                  o_dcache_ready,
    output logic [`WB_DATA_W-1:0] o_icache_rdata,
    output logic [`WB_DATA_W-1:0] o_dcache_rdata
);

    req_src_e src_q;
    logic     busy_q;

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            src_q  <= SRC_ICACHE;
            busy_q <= 1'b0;
        end
        else if (i_grant)
        begin
            src_q  <= i_src;
            busy_q <= 1'b1;
        end
        else if (i_beat_ack && i_last_beat)
            busy_q <= 1'b0;
    end

    // ready pulses in the same cycle as the ack
    assign o_icache_ready = busy_q && (src_q == SRC_ICACHE) && i_beat_ack;
    assign o_dcache_ready = busy_q && (src_q == SRC_DCACHE) && i_beat_ack;

    // data is only meaningful alongside the matching ready
    assign o_icache_rdata = i_wb_dat;
    assign o_dcache_rdata = i_wb_dat;

endmodule

//--- verilog/a25_wb_master.sv
/*
 * wishbone bus master for the instruction and data cache ports
 *  - request arbiter
 *  - burst sequencer driving the bus
 *  - response router back to the caches
 */
`include "wb_master_defines.svh"

module a25_wb_master
    import wb_master_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  quick_n_reset,
    input  icache_req_t           i_icache,
    input  dcache_req_t           i_dcache,
    output logic                  o_icache_ready,
    output logic                  o_dcache_ready,
    output logic [`WB_DATA_W-1:0] o_icache_rdata,
    output logic [`WB_DATA_W-1:0] o_dcache_rdata,
    output wb_master_t            o_wb,
    input  logic [`WB_DATA_W-1:0] i_wb_dat,
    input  logic                  i_wb_ack
);

    logic     grant;
    bus_req_t bus_req;
    logic     idle;
    logic     beat_ack;
    logic     last_beat;

    // picks a request only while the sequencer is idle
    wb_request_arbiter u_arbiter (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_icache      (i_icache),
        .i_dcache      (i_dcache),
        .i_idle        (idle),
        .o_grant       (grant),
        .o_bus_req     (bus_req)
    );

    wb_burst_sequencer u_sequencer (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_grant       (grant),
        .i_bus_req     (bus_req),
        .i_wb_ack      (i_wb_ack),
        .o_wb          (o_wb),
        .o_idle        (idle),
        .o_beat_ack    (beat_ack),
        .o_last_beat   (last_beat)
    );

    // source is captured on the same grant that loads the sequencer
    wb_response_router u_router (
        .i_clk          (i_clk),
        .quick_n_reset  (quick_n_reset),
        .i_grant        (grant),
        .i_src          (bus_req.src),
        .i_beat_ack     (beat_ack),
        .i_last_beat    (last_beat),
        .i_wb_dat       (i_wb_dat),
        .o_icache_ready (o_icache_ready),
        .o_dcache_ready (o_dcache_ready),
        .o_icache_rdata (o_icache_rdata),
        .o_dcache_rdata (o_dcache_rdata)
    );

endmodule

//--- dv/a25_wb_master_tb.sv
/*
 * testbench for the wishbone master
 *  - clock, reset and a word memory slave with random ack delays
 *  - LFSR, reference read function and a ready checker
 *  - directed tests for reads, line fills, byte writes and priority
 */
`include "wb_master_defines.svh"

module a25_wb_master_tb
    import wb_master_pkg::*;
();

    logic                  i_clk = 1'b0;
    logic                  quick_n_reset;
    icache_req_t           i_icache;
    dcache_req_t           i_dcache;
    logic                  o_icache_ready;
    logic                  o_dcache_ready;
    logic [`WB_DATA_W-1:0] o_icache_rdata;
    logic [`WB_DATA_W-1:0] o_dcache_rdata;
    wb_master_t            o_wb;
    logic [`WB_DATA_W-1:0] slave_dat;
    logic                  slave_ack;

    // slave memory and the shadow copy that the reference reads from
    logic [31:0] mem [256];
    logic [31:0] shadow [256];

    // slave state
    logic [31:0] lfsr;
    logic [1:0]  delay_left;
    logic        armed;
    logic [31:0] held_adr;
    logic [31:0] last_adr;
    logic [7:0]  widx;
    integer      idx_i;
    integer      bit_i;
    integer      slave_errors;

    // checker state
    integer      i_beat;
    integer      d_beat;
    integer      check_errors;
    logic [31:0] exp_i;
    logic [31:0] exp_d;

    // test sequence state
    integer      test_errors;
    integer      tests;
    integer      errs_before;
    integer      k;
    time         i_first;
    time         d_first;
    time         dummy_t;
    logic [3:0]  be_pat [8] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                4'b1100, 4'b0011, 4'b0110, 4'b1111};

    always #4 i_clk = ~i_clk;

    a25_wb_master dut (
        .i_clk          (i_clk),
        .quick_n_reset  (quick_n_reset),
        .i_icache       (i_icache),
        .i_dcache       (i_dcache),
        .o_icache_ready (o_icache_ready),
        .o_dcache_ready (o_dcache_ready),
        .o_icache_rdata (o_icache_rdata),
        .o_dcache_rdata (o_dcache_rdata),
        .o_wb           (o_wb),
        .i_wb_dat       (slave_dat),
        .i_wb_ack       (slave_ack)
    );

    // ====================
    // helper functions
    // ====================

    // fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // every byte of the start value depends on the word index
    function automatic logic [31:0] fill_word(input int i);
        logic [7:0] b;
        b = 8'(i);
        return {b ^ 8'h5a, ~b, b + 8'h33, b};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = old_w;
        if (be[0]) res[7:0]   = new_w[7:0];
        if (be[1]) res[15:8]  = new_w[15:8];
        if (be[2]) res[23:16] = new_w[23:16];
        if (be[3]) res[31:24] = new_w[31:24];
        return res;
    endfunction

    // the reference read walks through the words of the line and wraps
    function automatic logic [31:0] expected_read(input logic [31:0] addr, input int beat);
        logic [1:0] w;
        logic [7:0] idx;
        w   = addr[3:2] + 2'(beat);
        idx = {addr[9:4], w};
        return shadow[idx];
    endfunction

    // a single lane gives its own index, the upper halfword gives 2
    function automatic logic [1:0] expected_lane(input logic [3:0] be);
        if ($countones(be) == 1)
            return {be[3] | be[2], be[3] | be[1]};
        else if (be == 4'b1100)
            return 2'd2;
        return 2'd0;
    endfunction

    function automatic int total_errors();
        return test_errors + check_errors + slave_errors;
    endfunction

    // ====================
    // slave memory model
    // ====================

    initial
    begin
        slave_ack <= 1'b0;
        slave_dat <= '0;
        last_adr  <= '0;
        forever
        begin
            @(posedge i_clk);
            if (!quick_n_reset)
            begin
                slave_ack <= 1'b0;
                armed = 1'b0;
                delay_left = 2'd0;
                lfsr = 32'h16c6;
                slave_errors = 0;
                for (idx_i = 0; idx_i < 256; idx_i++)
                    mem[idx_i[7:0]] = fill_word(idx_i);
            end
            else if (slave_ack)
            begin
                // the beat completed at this edge, the next one draws a new delay
                slave_ack <= 1'b0;
                armed = 1'b0;
            end
            else if (o_wb.stb)
            begin
                if (!armed)
                begin
                    armed = 1'b1;
                    held_adr = o_wb.adr;
                    for (bit_i = 0; bit_i < 2; bit_i++)
                    begin
                        lfsr = lfsr_next(lfsr);
                        delay_left = {delay_left[0], lfsr[0]};
                    end
                end
                else if (o_wb.adr !== held_adr)
                begin
                    slave_errors++;
                    $display("[ERROR] t=%0t adr moved from %h to %h while stb waited",
                             $time, held_adr, o_wb.adr);
                end
                if (delay_left == 2'd0)
                begin
                    widx = o_wb.adr[9:2];
                    slave_ack <= 1'b1;
                    last_adr  <= o_wb.adr;
                    if (o_wb.we)
                    begin
                        if (o_wb.sel[0]) mem[widx][7:0]   = o_wb.dat[7:0];
                        if (o_wb.sel[1]) mem[widx][15:8]  = o_wb.dat[15:8];
                        if (o_wb.sel[2]) mem[widx][23:16] = o_wb.dat[23:16];
                        if (o_wb.sel[3]) mem[widx][31:24] = o_wb.dat[31:24];
                    end
                    else
                        slave_dat <= mem[widx];
                end
                else
                    delay_left = delay_left - 2'd1;
            end
        end
    end

    // ====================
    // ready checker
    // ====================

    // ready, read data and the request being answered are all stable at the falling edge
    always @(negedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            i_beat = 0;
            d_beat = 0;
            check_errors = 0;
        end
        else
        begin
            if (o_icache_ready)
            begin
                exp_i = expected_read(i_icache.address, i_beat);
                if (!i_icache.valid)
                begin
                    check_errors++;
                    $display("icache ready pulsed with no request pending at time %0t", $time);
                end
                else if (o_icache_rdata !== exp_i)
                begin
                    check_errors++;
                    $display("[ERROR] t=%0t icache beat %0d read %h, expected %h",
                             $time, i_beat, o_icache_rdata, exp_i);
                end
                i_beat = (i_beat + 1 == (i_icache.qword ? `WB_BURST_BEATS : 1)) ? 0 : i_beat + 1;
            end
            if (o_dcache_ready)
            begin
                exp_d = expected_read(i_dcache.address, d_beat);
                if (!i_dcache.valid)
                begin
                    check_errors++;
                    $display("dcache ready pulsed with no request pending at time %0t", $time);
                end
                // a write acknowledge carries no read data
                else if (!i_dcache.write && o_dcache_rdata !== exp_d)
                begin
                    check_errors++;
                    $display("[ERROR] t=%0t dcache beat %0d read %h, expected %h",
                             $time, d_beat, o_dcache_rdata, exp_d);
                end
                d_beat = (d_beat + 1 == ((i_dcache.qword && !i_dcache.write) ?
                          `WB_BURST_BEATS : 1)) ? 0 : d_beat + 1;
            end
        end
    end

    // ====================
    // request tasks
    // ====================

    task automatic abort_run(input string why);
        $display("%s at time %0t", why, $time);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic run_icache(input logic [31:0] addr, input logic qword, output time first_t);
        int seen;
        int waited;
        seen = 0;
        waited = 0;
        first_t = 0;
        @(posedge i_clk);
        i_icache <= '{valid: 1'b1, qword: qword, address: addr};
        while (seen < (qword ? `WB_BURST_BEATS : 1))
        begin
            @(posedge i_clk);
            waited++;
            if (o_icache_ready)
            begin
                if (seen == 0)
                    first_t = $time;
                seen++;
            end
            else if (waited > 100)
                abort_run("timed out waiting for an instruction ready");
        end
        // the last ready ended at this edge, so the request is dropped here
        i_icache.valid <= 1'b0;
    endtask

    task automatic run_dcache(input logic [31:0] addr, input logic qword, input logic wr,
                              input logic [3:0] be, input logic [31:0] wdata,
                              output time first_t);
        int seen;
        int waited;
        int beats;
        seen = 0;
        waited = 0;
        first_t = 0;
        beats = (qword && !wr) ? `WB_BURST_BEATS : 1;
        if (wr)
            shadow[addr[9:2]] = merge_bytes(shadow[addr[9:2]], wdata, be);
        @(posedge i_clk);
        i_dcache <= '{valid: 1'b1, qword: qword, write: wr, byte_enable: be,
                      write_data: wdata, address: addr};
        while (seen < beats)
        begin
            @(posedge i_clk);
            waited++;
            if (o_dcache_ready)
            begin
                if (seen == 0)
                    first_t = $time;
                seen++;
            end
            else if (waited > 100)
                abort_run("timed out waiting for a data ready");
        end
        i_dcache.valid <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests++;
        if (total_errors() == errs_at_start)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: FAILED with %0d errors", tests, name,
                     total_errors() - errs_at_start);
    endtask

    task automatic check_adr(input logic [31:0] expected);
        if (last_adr !== expected)
        begin
            test_errors++;
            $display("[ERROR] t=%0t last adr %h, expected %h", $time, last_adr, expected);
        end
    endtask

    // ====================
    // test sequence
    // ====================

    initial
    begin
        i_icache      <= '0;
        i_dcache      <= '0;
        quick_n_reset <= 1'b0;
        test_errors = 0;
        tests = 0;
        for (k = 0; k < 256; k++)
            shadow[k[7:0]] = fill_word(k);
        repeat (3) @(posedge i_clk);
        quick_n_reset <= 1'b1;

        errs_before = total_errors();
        repeat (2) @(posedge i_clk);
        if ({o_wb.cyc, o_wb.stb, o_wb.we, o_icache_ready, o_dcache_ready} !== 5'b0)
        begin
            test_errors++;
            $display("[ERROR] t=%0t bus or ready active after reset", $time);
        end
        finish_test("reset state", errs_before);

        errs_before = total_errors();
        run_icache(32'h106, 1'b0, dummy_t);
        check_adr(32'h104);
        finish_test("single instruction read", errs_before);

        // starts at word 2, so the last beat sits on word 1
        errs_before = total_errors();
        run_icache(32'h128, 1'b1, dummy_t);
        check_adr(32'h124);
        finish_test("wrapping line fill", errs_before);

        errs_before = total_errors();
        for (k = 0; k < 8; k++)
        begin
            run_dcache(32'h40, 1'b0, 1'b1, be_pat[k[2:0]],
                       {8'hd0 + 8'(k), 8'hc0 + 8'(k), 8'hb0 + 8'(k), 8'ha0 + 8'(k)}, dummy_t);
            check_adr({30'h10, expected_lane(be_pat[k[2:0]])});
        end
        run_dcache(32'h40, 1'b0, 1'b0, 4'hf, '0, dummy_t);
        finish_test("byte enable writes", errs_before);

        errs_before = total_errors();
        fork
            run_dcache(32'h4c, 1'b1, 1'b0, 4'hf, '0, d_first);
            run_icache(32'h200, 1'b1, i_first);
        join
        if (!(d_first < i_first))
        begin
            test_errors++;
            $display("the instruction port was served before the data port");
        end
        finish_test("data over instruction priority", errs_before);

        errs_before = total_errors();
        for (k = 0; k < 8; k++)
        begin
            run_dcache(32'h80 + {28'd0, k[1:0], 2'b00}, 1'b0, 1'b1, 4'(k + 1),
                       {4{8'(k * 37)}}, dummy_t);
            run_dcache(32'h80 + {28'd0, k[1:0], 2'b00}, 1'b1, 1'b0, 4'hf, '0, dummy_t);
            run_icache(32'h300 + {26'd0, k[3:0], 2'b00}, k[0], dummy_t);
        end
        finish_test("mixed traffic", errs_before);

        $display("%0d tests, %0d errors", tests, total_errors());
        if (total_errors() == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- a25_wb_master.f
+incdir+verilog
verilog/wb_master_pkg.sv
verilog/wb_request_arbiter.sv
verilog/wb_burst_sequencer.sv
verilog/wb_response_router.sv
verilog/a25_wb_master.sv
dv/a25_wb_master_tb.sv

//--- Makefile
# Verilator build and run of the wishbone master testbench

TOOL  := verilator
FLAGS := --binary --timing -j 0
TOP   := a25_wb_master_tb
FLIST := a25_wb_master.f
OBJ   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ)
